/* all.f */
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/core.sv
tests/tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module tb_core \
    -f all.f \
    -Mdir obj_dir

./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

/* tests/core_trace.txt */
// Word 0 program length, word 1 store count, then program words from address 0
// then one record per store: word address, byte enables, data
00000032 0000000a
// ALU chain with forwarding
00500093 00708113 002081b3 40118233 10302023 10402223
0021c2b3 00429313 10602423 800003b7 4043d413 10802623
001424b3 0080b533 00151513 00a4e5b3 10b02823
// Load-use
10002603 001606b3 10d02a23
// Branches, squashed slots hold a store to 0x1f0
00410663 1e102823 1e102823
00209663 1e102823 1e102823
00144663 1e102823 1e102823
00145463 10102c23
0080d663 1e102823 1e102823
00208463 00109463 0080c463
// JAL, JALR with odd target, AUIPC, final loop
00c0076f 1e102823 1e102823 10e02e23
0b900793 00078867 1e102823 1e102823 1e102823
13002023 00001897 13102223 0000006f
// Expected stores
00000040 0000000f 00000011
00000041 0000000f 0000000c
00000042 0000000f 000001d0
00000043 0000000f f8000000
00000044 0000000f 00000003
00000045 0000000f 00000016
00000046 0000000f 00000005
00000047 0000000f 00000098
00000048 0000000f 000000ac
00000049 0000000f 000010bc

/* tests/tb_core.sv */
`timescale 1ns/1ns

module tb_core import rv_isa_pkg::*; ();
    localparam xlen_t RESET_PC    = 32'h0000_0000;
    localparam int    TRACE_WORDS = 82;
    localparam int    DRAIN       = 20; // Cycles to watch for stray stores

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_ready_i;
    xlen_t       instr_data_i;
    logic        data_ready_i;
    xlen_t       data_rdata_i;
    logic [29:0] instr_addr_o;
    logic        data_en_o;
    logic [29:0] data_addr_o;
    logic [3:0]  data_wen_o;
    xlen_t       data_wdata_o;

    xlen_t       trace_mem [0:TRACE_WORDS-1];
    xlen_t       imem [0:255];
    xlen_t       dmem [0:255];
    logic [29:0] exp_addr [0:63];
    logic [3:0]  exp_wen [0:63];
    xlen_t       exp_data [0:63];
    int          prog_len;
    int          store_cnt;
    int          store_idx;
    int          value_errors;
    int          other_errors;
    logic [31:0] lfsr_q;

    core #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .instr_ready_i(instr_ready_i),
        .instr_data_i(instr_data_i),
        .data_ready_i(data_ready_i),
        .data_rdata_i(data_rdata_i),
        .instr_addr_o(instr_addr_o),
        .data_en_o(data_en_o),
        .data_addr_o(data_addr_o),
        .data_wen_o(data_wen_o),
        .data_wdata_o(data_wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Memory models answer in the same cycle
    assign instr_data_i = (instr_addr_o < 30'd256) ? imem[instr_addr_o[7:0]] : 32'h0000_0013;
    assign data_rdata_i = (data_addr_o < 30'd256) ? dmem[data_addr_o[7:0]]
                                                  : {2'b10, data_addr_o};

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Ready about three cycles in four
    task automatic draw_ready(output logic rdy);
        logic a;
        logic b;
        lfsr_q = lfsr_next(lfsr_q);
        a = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        b = lfsr_q[0];
        rdy = a | b;
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [29:0] got,
                              input logic [29:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_enables(input string name, input logic [3:0] got,
                                 input logic [3:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // Accesses complete at the next rising edge so values are stable here
    always @(negedge clk_i) begin
        // The program's first data access is a store
        if (rst_n_i && store_idx == 0 && (data_en_o != (data_wen_o != 4'h0))) begin
            other_errors++;
            $display("Data port was active before the first store");
        end
        if (rst_n_i && data_en_o && data_ready_i && data_wen_o != 4'h0) begin
            if (store_idx < store_cnt) begin
                check_addr("data_addr_o", data_addr_o, exp_addr[store_idx]);
                check_enables("data_wen_o", data_wen_o, exp_wen[store_idx]);
                check_word("data_wdata_o", data_wdata_o, exp_data[store_idx]);
            end else begin
                other_errors++;
                $display("Store to word address %h came after the last expected store",
                         data_addr_o);
            end
            if (data_addr_o < 30'd256) begin
                dmem[data_addr_o[7:0]] = data_wdata_o;
            end
            store_idx++;
        end
    end

    initial begin
        wait (prog_len > 0);
        repeat (prog_len * 40) @(posedge clk_i);
        $display("Timeout with %0d of %0d stores seen", store_idx, store_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic rdy;
        rst_n_i       = 1'b0;
        instr_ready_i = 1'b1;
        data_ready_i  = 1'b1;
        lfsr_q        = 32'ha536;
        store_idx     = 0;
        value_errors  = 0;
        other_errors  = 0;

        $readmemh("tests/core_trace.txt", trace_mem);
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013; // NOP
            dmem[i] = 32'hd000_0000 | i;
        end
        for (int i = 0; i < trace_mem[0]; i++) begin
            imem[i] = trace_mem[i + 2];
        end
        for (int i = 0; i < trace_mem[1]; i++) begin
            exp_addr[i] = trace_mem[2 + trace_mem[0] + 3 * i][29:0];
            exp_wen[i]  = trace_mem[3 + trace_mem[0] + 3 * i][3:0];
            exp_data[i] = trace_mem[4 + trace_mem[0] + 3 * i];
        end
        store_cnt = trace_mem[1];
        prog_len  = trace_mem[0];

        repeat (10) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        // First cycle out of reset
        @(negedge clk_i);
        check_addr("instr_addr_o", instr_addr_o, RESET_PC[31:2]);
        check_enables("data_wen_o", data_wen_o, 4'h0);
        if (data_en_o !== 1'b0) begin
            other_errors++;
            $display("Data port was enabled in the first cycle after reset");
        end

        while (store_idx < store_cnt) begin
            @(posedge clk_i);
            #1;
            draw_ready(rdy);
            instr_ready_i = rdy;
            draw_ready(rdy);
            data_ready_i = rdy;
        end
        repeat (DRAIN) @(posedge clk_i);

        if (store_idx != store_cnt) begin
            other_errors++;
            $display("Saw %0d stores where the trace lists %0d", store_idx, store_cnt);
        end
        $display("Value errors %0d, other errors %0d, stores %0d of %0d",
                 value_errors, other_errors, store_idx, store_cnt);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* design/core.sv */
`timescale 1ns/1ns

module core import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_ready_i,
    input  xlen_t       instr_data_i,
    input  logic        data_ready_i,
    input  xlen_t       data_rdata_i,
    output logic [29:0] instr_addr_o,
    output logic        data_en_o,
    output logic [29:0] data_addr_o,
    output logic [3:0]  data_wen_o,
    output xlen_t       data_wdata_o
);
    logic       freeze, stall, redirect;
    xlen_t      redirect_pc;
    // IF/ID
    logic       if_valid;
    xlen_t      if_instr, if_pc;
    // ID/EX
    logic       id_valid, id_op1_pc, id_op2_imm, id_branch, id_jump, id_jalr;
    logic       id_load, id_store, id_reg_wen;
    xlen_t      id_pc, id_rs1_val, id_rs2_val, id_imm;
    reg_idx_t   id_rs1, id_rs2, id_rd;
    alu_op_e    id_alu_op;
    logic [2:0] id_funct3;
    wb_sel_e    id_wb_sel;
    // EX/MEM
    logic       ex_valid, ex_load, ex_store, ex_reg_wen;
    xlen_t      ex_alu, ex_store_data, ex_pc4;
    reg_idx_t   ex_rd;
    wb_sel_e    ex_wb_sel;
    // MEM/WB
    logic       wb_valid, wb_reg_wen, wb_en;
    reg_idx_t   wb_rd;
    wb_sel_e    wb_sel;
    xlen_t      wb_alu, wb_load, wb_pc4, wb_data;

    assign freeze = data_en_o & ~data_ready_i; // Data port busy stops every stage
    assign wb_en  = wb_valid & wb_reg_wen;

    always_comb begin
        case (wb_sel)
            WB_LOAD: wb_data = wb_load;
            WB_PC4:  wb_data = wb_pc4;
            default: wb_data = wb_alu;
        endcase
    end

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .freeze_i(freeze),
        .stall_i(stall),
        .redirect_i(redirect),
        .redirect_pc_i(redirect_pc),
        .instr_ready_i(instr_ready_i),
        .instr_data_i(instr_data_i),
        .instr_addr_o(instr_addr_o),
        .if_valid_o(if_valid),
        .if_instr_o(if_instr),
        .if_pc_o(if_pc)
    );

    decode_stage u_decode (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .freeze_i(freeze),
        .flush_i(redirect),
        .if_valid_i(if_valid),
        .if_instr_i(if_instr),
        .if_pc_i(if_pc),
        .wb_en_i(wb_en),
        .wb_rd_i(wb_rd),
        .wb_data_i(wb_data),
        .stall_o(stall),
        .id_valid_o(id_valid),
        .id_pc_o(id_pc),
        .id_rs1_o(id_rs1),
        .id_rs2_o(id_rs2),
        .id_rs1_val_o(id_rs1_val),
        .id_rs2_val_o(id_rs2_val),
        .id_imm_o(id_imm),
        .id_rd_o(id_rd),
        .id_alu_op_o(id_alu_op),
        .id_op1_pc_o(id_op1_pc),
        .id_op2_imm_o(id_op2_imm),
        .id_branch_o(id_branch),
        .id_jump_o(id_jump),
        .id_jalr_o(id_jalr),
        .id_funct3_o(id_funct3),
        .id_load_o(id_load),
        .id_store_o(id_store),
        .id_reg_wen_o(id_reg_wen),
        .id_wb_sel_o(id_wb_sel)
    );

    execute_stage u_execute (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .freeze_i(freeze),
        .id_valid_i(id_valid),
        .id_pc_i(id_pc),
        .id_rs1_i(id_rs1),
        .id_rs2_i(id_rs2),
        .id_rs1_val_i(id_rs1_val),
        .id_rs2_val_i(id_rs2_val),
        .id_imm_i(id_imm),
        .id_rd_i(id_rd),
        .id_alu_op_i(id_alu_op),
        .id_op1_pc_i(id_op1_pc),
        .id_op2_imm_i(id_op2_imm),
        .id_branch_i(id_branch),
        .id_jump_i(id_jump),
        .id_jalr_i(id_jalr),
        .id_funct3_i(id_funct3),
        .id_load_i(id_load),
        .id_store_i(id_store),
        .id_reg_wen_i(id_reg_wen),
        .id_wb_sel_i(id_wb_sel),
        .mem_valid_i(ex_valid),
        .mem_reg_wen_i(ex_reg_wen),
        .mem_rd_i(ex_rd),
        .mem_alu_i(ex_alu),
        .wb_valid_i(wb_valid),
        .wb_reg_wen_i(wb_reg_wen),
        .wb_rd_i(wb_rd),
        .wb_data_i(wb_data),
        .redirect_o(redirect),
        .redirect_pc_o(redirect_pc),
        .ex_valid_o(ex_valid),
        .ex_alu_o(ex_alu),
        .ex_store_data_o(ex_store_data),
        .ex_rd_o(ex_rd),
        .ex_load_o(ex_load),
        .ex_store_o(ex_store),
        .ex_reg_wen_o(ex_reg_wen),
        .ex_wb_sel_o(ex_wb_sel),
        .ex_pc4_o(ex_pc4)
    );

    memory_stage u_memory (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .freeze_i(freeze),
        .ex_valid_i(ex_valid),
        .ex_alu_i(ex_alu),
        .ex_store_data_i(ex_store_data),
        .ex_rd_i(ex_rd),
        .ex_load_i(ex_load),
        .ex_store_i(ex_store),
        .ex_reg_wen_i(ex_reg_wen),
        .ex_wb_sel_i(ex_wb_sel),
        .ex_pc4_i(ex_pc4),
        .data_rdata_i(data_rdata_i),
        .data_en_o(data_en_o),
        .data_addr_o(data_addr_o),
        .data_wen_o(data_wen_o),
        .data_wdata_o(data_wdata_o),
        .wb_valid_o(wb_valid),
        .wb_reg_wen_o(wb_reg_wen),
        .wb_rd_o(wb_rd),
        .wb_sel_o(wb_sel),
        .wb_alu_o(wb_alu),
        .wb_load_o(wb_load),
        .wb_pc4_o(wb_pc4)
    );

endmodule

/* design/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        freeze_i,
    input  logic        ex_valid_i,
    input  xlen_t       ex_alu_i,
    input  xlen_t       ex_store_data_i,
    input  reg_idx_t    ex_rd_i,
    input  logic        ex_load_i,
    input  logic        ex_store_i,
    input  logic        ex_reg_wen_i,
    input  wb_sel_e     ex_wb_sel_i,
    input  xlen_t       ex_pc4_i,
    input  xlen_t       data_rdata_i,
    output logic        data_en_o,
    output logic [29:0] data_addr_o,
    output logic [3:0]  data_wen_o,
    output xlen_t       data_wdata_o,
    output logic        wb_valid_o,
    output logic        wb_reg_wen_o,
    output reg_idx_t    wb_rd_o,
    output wb_sel_e     wb_sel_o,
    output xlen_t       wb_alu_o,
    output xlen_t       wb_load_o,
    output xlen_t       wb_pc4_o
);
    // Held steady by the freeze until the port is ready
    assign data_en_o    = ex_valid_i && (ex_load_i || ex_store_i);
    assign data_addr_o  = ex_alu_i[31:2];
    assign data_wen_o   = (ex_valid_i && ex_store_i) ? 4'hf : 4'h0; // SW only
    assign data_wdata_o = ex_store_data_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else if (!freeze_i) begin
            wb_valid_o <= ex_valid_i;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            wb_reg_wen_o <= ex_reg_wen_i;
            wb_rd_o      <= ex_rd_i;
            wb_sel_o     <= ex_wb_sel_i;
            wb_alu_o     <= ex_alu_i;
            wb_load_o    <= data_rdata_i; // Valid in the ready cycle
            wb_pc4_o     <= ex_pc4_i;
        end
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       freeze_i,
    input  logic       id_valid_i,
    input  xlen_t      id_pc_i,
    input  reg_idx_t   id_rs1_i,
    input  reg_idx_t   id_rs2_i,
    input  xlen_t      id_rs1_val_i,
    input  xlen_t      id_rs2_val_i,
    input  xlen_t      id_imm_i,
    input  reg_idx_t   id_rd_i,
    input  alu_op_e    id_alu_op_i,
    input  logic       id_op1_pc_i,
    input  logic       id_op2_imm_i,
    input  logic       id_branch_i,
    input  logic       id_jump_i,
    input  logic       id_jalr_i,
    input  logic [2:0] id_funct3_i,
    input  logic       id_load_i,
    input  logic       id_store_i,
    input  logic       id_reg_wen_i,
    input  wb_sel_e    id_wb_sel_i,
    input  logic       mem_valid_i,
    input  logic       mem_reg_wen_i,
    input  reg_idx_t   mem_rd_i,
    input  xlen_t      mem_alu_i,
    input  logic       wb_valid_i,
    input  logic       wb_reg_wen_i,
    input  reg_idx_t   wb_rd_i,
    input  xlen_t      wb_data_i,
    output logic       redirect_o,
    output xlen_t      redirect_pc_o,
    output logic       ex_valid_o,
    output xlen_t      ex_alu_o,
    output xlen_t      ex_store_data_o,
    output reg_idx_t   ex_rd_o,
    output logic       ex_load_o,
    output logic       ex_store_o,
    output logic       ex_reg_wen_o,
    output wb_sel_e    ex_wb_sel_o,
    output xlen_t      ex_pc4_o
);
    fwd_sel_e fwd_a, fwd_b;
    xlen_t    exmem_val, rs1_fwd, rs2_fwd;
    xlen_t    op_a, op_b, alu_res, pc4;
    logic     take_branch;

    // Newest producer wins
    function automatic fwd_sel_e fwd_src(input reg_idx_t rs);
        if (rs != '0 && mem_valid_i && mem_reg_wen_i && mem_rd_i == rs) begin
            return FWD_EXMEM;
        end else if (rs != '0 && wb_valid_i && wb_reg_wen_i && wb_rd_i == rs) begin
            return FWD_MEMWB;
        end
        return FWD_RF;
    endfunction

    // A jump in EX/MEM forwards its link value
    assign exmem_val = (ex_wb_sel_o == WB_PC4) ? ex_pc4_o : mem_alu_i;

    always_comb begin
        fwd_a = fwd_src(id_rs1_i);
        fwd_b = fwd_src(id_rs2_i);
        case (fwd_a)
            FWD_EXMEM: rs1_fwd = exmem_val;
            FWD_MEMWB: rs1_fwd = wb_data_i;
            default:   rs1_fwd = id_rs1_val_i;
        endcase
        case (fwd_b)
            FWD_EXMEM: rs2_fwd = exmem_val;
            FWD_MEMWB: rs2_fwd = wb_data_i;
            default:   rs2_fwd = id_rs2_val_i;
        endcase
    end

    assign op_a = id_op1_pc_i ? id_pc_i : rs1_fwd;
    assign op_b = id_op2_imm_i ? id_imm_i : rs2_fwd;
    assign pc4  = id_pc_i + 32'd4;

    always_comb begin
        case (id_alu_op_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = xlen_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        case (branch_funct3_e'(id_funct3_i))
            F3_BEQ:  take_branch = (rs1_fwd == rs2_fwd);
            F3_BNE:  take_branch = (rs1_fwd != rs2_fwd);
            F3_BLT:  take_branch = ($signed(rs1_fwd) < $signed(rs2_fwd));
            F3_BGE:  take_branch = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            default: take_branch = 1'b0;
        endcase
    end

    assign redirect_o    = id_valid_i && (id_jump_i || (id_branch_i && take_branch));
    assign redirect_pc_o = id_branch_i ? (id_pc_i + id_imm_i)
                                       : {alu_res[31:1], alu_res[0] & ~id_jalr_i};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (!freeze_i) begin
            ex_valid_o <= id_valid_i;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            ex_alu_o        <= alu_res;
            ex_store_data_o <= rs2_fwd;
            ex_rd_o         <= id_rd_i;
            ex_load_o       <= id_load_i;
            ex_store_o      <= id_store_i;
            ex_reg_wen_o    <= id_reg_wen_i;
            ex_wb_sel_o     <= id_wb_sel_i;
            ex_pc4_o        <= pc4;
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       freeze_i,
    input  logic       flush_i,
    input  logic       if_valid_i,
    input  xlen_t      if_instr_i,
    input  xlen_t      if_pc_i,
    input  logic       wb_en_i,
    input  reg_idx_t   wb_rd_i,
    input  xlen_t      wb_data_i,
    output logic       stall_o,
    output logic       id_valid_o,
    output xlen_t      id_pc_o,
    output reg_idx_t   id_rs1_o,
    output reg_idx_t   id_rs2_o,
    output xlen_t      id_rs1_val_o,
    output xlen_t      id_rs2_val_o,
    output xlen_t      id_imm_o,
    output reg_idx_t   id_rd_o,
    output alu_op_e    id_alu_op_o,
    output logic       id_op1_pc_o,
    output logic       id_op2_imm_o,
    output logic       id_branch_o,
    output logic       id_jump_o,
    output logic       id_jalr_o,
    output logic [2:0] id_funct3_o,
    output logic       id_load_o,
    output logic       id_store_o,
    output logic       id_reg_wen_o,
    output wb_sel_e    id_wb_sel_o
);
    xlen_t      regs_q [1:31]; // x0 is not stored
    reg_idx_t   rs1, rs2, rd;
    rv_opcode_e opcode;
    logic [2:0] funct3;
    xlen_t      rs1_val, rs2_val, imm;
    alu_op_e    alu_op;
    logic       op1_pc, op2_imm, branch, jump, jalr, load, store, reg_wen;
    wb_sel_e    wb_sel;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic f7_b5,
                                           input logic is_reg);
        case (alu_funct3_e'(f3))
            F3_ADD:  return (is_reg && f7_b5) ? ALU_SUB : ALU_ADD; // No SUBI
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return f7_b5 ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1    = if_instr_i[19:15];
    assign rs2    = if_instr_i[24:20];
    assign rd     = if_instr_i[11:7];
    assign funct3 = if_instr_i[14:12];
    assign opcode = rv_opcode_e'(if_instr_i[6:0]);

    always_ff @(posedge clk_i) begin
        if (wb_en_i && wb_rd_i != '0) begin
            regs_q[wb_rd_i] <= wb_data_i;
        end
    end

    // Same-cycle write shows through to the read
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb_en_i && wb_rd_i == rs1) ? wb_data_i : regs_q[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb_en_i && wb_rd_i == rs2) ? wb_data_i : regs_q[rs2];

    always_comb begin
        imm     = {{20{if_instr_i[31]}}, if_instr_i[31:20]}; // I-type by default
        alu_op  = ALU_ADD;
        op1_pc  = 1'b0;
        op2_imm = 1'b1;
        branch  = 1'b0;
        jump    = 1'b0;
        jalr    = 1'b0;
        load    = 1'b0;
        store   = 1'b0;
        reg_wen = 1'b0;
        wb_sel  = WB_ALU;
        case (opcode)
            OPC_OP: begin
                op2_imm = 1'b0;
                alu_op  = alu_decode(funct3, if_instr_i[30], 1'b1);
                reg_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op  = alu_decode(funct3, if_instr_i[30], 1'b0);
                reg_wen = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                imm     = {if_instr_i[31:12], 12'b0};
                alu_op  = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                op1_pc  = (opcode == OPC_AUIPC);
                reg_wen = 1'b1;
            end
            OPC_LOAD: begin
                load    = 1'b1;
                reg_wen = 1'b1;
                wb_sel  = WB_LOAD;
            end
            OPC_STORE: begin
                imm   = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
                store = 1'b1;
            end
            OPC_BRANCH: begin
                imm     = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                           if_instr_i[30:25], if_instr_i[11:8], 1'b0};
                op2_imm = 1'b0;
                branch  = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                if (opcode == OPC_JAL) begin
                    imm = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                           if_instr_i[20], if_instr_i[30:21], 1'b0};
                end
                op1_pc  = (opcode == OPC_JAL); // ALU forms the jump target
                jump    = 1'b1;
                jalr    = (opcode == OPC_JALR);
                reg_wen = 1'b1;
                wb_sel  = WB_PC4;
            end
            default: ; // Unknown opcode decodes as a NOP
        endcase
    end

    // Load-use hazard holds IF/ID one cycle and sends a bubble into EX
    assign stall_o = id_valid_o && id_load_o && (id_rd_o != '0) && if_valid_i &&
                     ((id_rd_o == rs1) || (id_rd_o == rs2));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else if (!freeze_i) begin
            id_valid_o <= if_valid_i && !flush_i && !stall_o;
        end
    end

    // ID/EX payload qualified by id_valid_o
    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            id_pc_o      <= if_pc_i;
            id_rs1_o     <= rs1;
            id_rs2_o     <= rs2;
            id_rs1_val_o <= rs1_val;
            id_rs2_val_o <= rs2_val;
            id_imm_o     <= imm;
            id_rd_o      <= rd;
            id_alu_op_o  <= alu_op;
            id_op1_pc_o  <= op1_pc;
            id_op2_imm_o <= op2_imm;
            id_branch_o  <= branch;
            id_jump_o    <= jump;
            id_jalr_o    <= jalr;
            id_funct3_o  <= funct3;
            id_load_o    <= load;
            id_store_o   <= store;
            id_reg_wen_o <= reg_wen;
            id_wb_sel_o  <= wb_sel;
        end
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage import rv_isa_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        freeze_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  xlen_t       redirect_pc_i,
    input  logic        instr_ready_i,
    input  xlen_t       instr_data_i,
    output logic [29:0] instr_addr_o,
    output logic        if_valid_o,
    output xlen_t       if_instr_o,
    output xlen_t       if_pc_o
);
    xlen_t pc_q;
    logic  accept;

    assign instr_addr_o = pc_q[31:2]; // Word address to the instruction port
    assign accept       = !freeze_i && !stall_i && !redirect_i && instr_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            if_valid_o <= 1'b0;
        end else if (!freeze_i) begin
            if (redirect_i) begin
                pc_q       <= redirect_pc_i;
                if_valid_o <= 1'b0; // Drop the word fetched this cycle
            end else if (!stall_i) begin
                if_valid_o <= instr_ready_i; // Bubble while the port is busy
                if (instr_ready_i) begin
                    pc_q <= pc_q + 32'd4;
                end
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            if_instr_o <= instr_data_i;
            if_pc_o    <= pc_q;
        end
    end

endmodule

/* design/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // ALU operation carried from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

endpackage

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } rv_opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000, // ADD and SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101, // SRL and SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_funct3_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001,
        F3_BLT = 3'b100,
        F3_BGE = 3'b101
    } branch_funct3_e;

endpackage
